// File: fft16_butterfly.sv
module fft16_butterfly (
	input  fft16_pkg::cplx_t i_top,
	input  fft16_pkg::cplx_t i_bot,
	input  fft16_pkg::cplx_t i_tw,
	output fft16_pkg::cplx_t o_top,
	output fft16_pkg::cplx_t o_bot
);

	// full width products plus one bit for the sum
	logic signed [2*fft16_pkg::WORD_SIZE:0] acc_re;
	logic signed [2*fft16_pkg::WORD_SIZE:0] acc_im;
	logic signed [2*fft16_pkg::WORD_SIZE:0] shr_re;
	logic signed [2*fft16_pkg::WORD_SIZE:0] shr_im;
	fft16_pkg::cplx_t prod;

	//////////////////////////////////////////////////
	// complex multiply bot * w
	//////////////////////////////////////////////////
	assign acc_re = i_bot.re * i_tw.re - i_bot.im * i_tw.im;
	assign acc_im = i_bot.re * i_tw.im + i_bot.im * i_tw.re;

	// drop the fraction bits of the twiddle
	assign shr_re = acc_re >>> fft16_pkg::FRACTION;
	assign shr_im = acc_im >>> fft16_pkg::FRACTION;

	assign prod.re = shr_re[fft16_pkg::WORD_SIZE-1:0];
	assign prod.im = shr_im[fft16_pkg::WORD_SIZE-1:0];

	//////////////////////////////////////////////////
	// add and subtract, wrapping
	//////////////////////////////////////////////////
	assign o_top.re = i_top.re + prod.re;
	assign o_top.im = i_top.im + prod.im;
	assign o_bot.re = i_top.re - prod.re;
	assign o_bot.im = i_top.im - prod.im;

endmodule

// File: fft16_pkg.sv
package fft16_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////
	localparam int N_POINTS  = 16;
	localparam int N_STAGES  = 4;
	localparam int N_BFLY    = 8;
	localparam int WORD_SIZE = 16;
	localparam int FRACTION  = 8;

	//////////////////////////////////////////////////
	// data types
	//////////////////////////////////////////////////

	// signed fixed point, FRACTION bits below the point
	typedef logic signed [WORD_SIZE-1:0] sample_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	// point 0 sits in the low bits
	typedef cplx_t [N_POINTS-1:0] frame_t;

	// one entry per butterfly lane
	typedef cplx_t [N_BFLY-1:0] bfly_vec_t;

	// k selects W16^k
	typedef logic [2:0] tw_idx_t;

	typedef tw_idx_t [N_BFLY-1:0] tw_vec_t;

	typedef logic [1:0] stage_t;

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////
	typedef enum logic {
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_t;

endpackage

// File: fft16_sequencer.sv
module fft16_sequencer (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_start,
	input  fft16_pkg::frame_t   i_frame,
	input  fft16_pkg::frame_t   i_frame_next,
	output fft16_pkg::stage_t   o_stage,
	output fft16_pkg::frame_t   o_frame,
	output logic                o_busy,
	output logic                o_done
);

	fft16_pkg::seq_state_t state;
	fft16_pkg::stage_t     stage;
	fft16_pkg::frame_t     frame_q;
	logic                  done_q;

	//////////////////////////////////////////////////
	// state machine, stage counter, frame register
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state   <= fft16_pkg::SEQ_IDLE;
			stage   <= '0;
			frame_q <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				fft16_pkg::SEQ_IDLE: begin
					if (i_start) begin
						frame_q <= i_frame;
						stage   <= '0;
						state   <= fft16_pkg::SEQ_RUN;
					end
				end
				fft16_pkg::SEQ_RUN: begin
					frame_q <= i_frame_next;
					stage   <= stage + 2'd1;
					// last stage written, counter wraps back to 0
					if (stage == 2'(fft16_pkg::N_STAGES - 1)) begin
						state  <= fft16_pkg::SEQ_IDLE;
						done_q <= 1'b1;
					end
				end
				default: state <= fft16_pkg::SEQ_IDLE;
			endcase
		end
	end

	assign o_stage = stage;
	assign o_frame = frame_q;
	assign o_busy  = (state == fft16_pkg::SEQ_RUN);
	assign o_done  = done_q;

endmodule

// File: fft16_stage_router.sv
module fft16_stage_router (
	input  fft16_pkg::stage_t    i_stage,
	input  fft16_pkg::frame_t    i_frame,
	input  fft16_pkg::bfly_vec_t i_bfly_top,
	input  fft16_pkg::bfly_vec_t i_bfly_bot,
	output fft16_pkg::bfly_vec_t o_top,
	output fft16_pkg::bfly_vec_t o_bot,
	output fft16_pkg::tw_vec_t   o_tw_idx,
	output fft16_pkg::frame_t    o_frame_next
);

	function automatic logic [3:0] bit_rev(input logic [3:0] idx);
		return {idx[0], idx[1], idx[2], idx[3]};
	endfunction

	logic [3:0] span;
	logic [3:0] mask;

	// butterfly span doubles every stage
	assign span = 4'd1 << i_stage;
	assign mask = span - 4'd1;

	//////////////////////////////////////////////////
	// gather operands and twiddles, scatter results
	//////////////////////////////////////////////////
	always_comb begin
		logic [3:0] lane;
		logic [3:0] k;
		logic [3:0] top_idx;
		logic [3:0] bot_idx;
		logic [3:0] src_top;
		logic [3:0] src_bot;

		o_frame_next = i_frame;
		for (int b = 0; b < fft16_pkg::N_BFLY; b++) begin
			lane = 4'(b);
			k = lane & mask;
			// group base is (b div h) * 2h
			top_idx = ((lane & ~mask) << 1) | k;
			bot_idx = top_idx | span;

			// first stage reads the natural order frame in bit reversed order
			if (i_stage == 2'd0) begin
				src_top = bit_rev(top_idx);
				src_bot = bit_rev(bot_idx);
			end else begin
				src_top = top_idx;
				src_bot = bot_idx;
			end

			o_top[b] = i_frame[src_top];
			o_bot[b] = i_frame[src_bot];
			o_tw_idx[b] = 3'(k << (2'd3 - i_stage));

			o_frame_next[top_idx] = i_bfly_top[b];
			o_frame_next[bot_idx] = i_bfly_bot[b];
		end
	end

endmodule

// File: fft16_top.sv
module fft16_top (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_start,
	input  fft16_pkg::frame_t i_frame,
	output fft16_pkg::frame_t o_frame,
	output logic              o_busy,
	output logic              o_done
);

	fft16_pkg::stage_t    stage;
	fft16_pkg::frame_t    frame_cur;
	fft16_pkg::frame_t    frame_next;
	fft16_pkg::bfly_vec_t op_top;
	fft16_pkg::bfly_vec_t op_bot;
	fft16_pkg::bfly_vec_t res_top;
	fft16_pkg::bfly_vec_t res_bot;
	fft16_pkg::bfly_vec_t tw;
	fft16_pkg::tw_vec_t   tw_idx;

	fft16_sequencer u_sequencer (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_start      (i_start),
		.i_frame      (i_frame),
		.i_frame_next (frame_next),
		.o_stage      (stage),
		.o_frame      (frame_cur),
		.o_busy       (o_busy),
		.o_done       (o_done)
	);

	fft16_stage_router u_router (
		.i_stage      (stage),
		.i_frame      (frame_cur),
		.i_bfly_top   (res_top),
		.i_bfly_bot   (res_bot),
		.o_top        (op_top),
		.o_bot        (op_bot),
		.o_tw_idx     (tw_idx),
		.o_frame_next (frame_next)
	);

	fft16_twiddle_rom u_twiddle_rom (
		.i_tw_idx (tw_idx),
		.o_tw     (tw)
	);

	// one set of butterflies, reused by every stage
	for (genvar b = 0; b < fft16_pkg::N_BFLY; b++) begin : g_bfly
		fft16_butterfly u_butterfly (
			.i_top (op_top[b]),
			.i_bot (op_bot[b]),
			.i_tw  (tw[b]),
			.o_top (res_top[b]),
			.o_bot (res_bot[b])
		);
	end

	assign o_frame = frame_cur;

endmodule

// File: fft16_twiddle_rom.sv
module fft16_twiddle_rom (
	input  fft16_pkg::tw_vec_t   i_tw_idx,
	output fft16_pkg::bfly_vec_t o_tw
);

	// W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16), scaled by 256
	function automatic fft16_pkg::cplx_t tw_lookup(input fft16_pkg::tw_idx_t k);
		fft16_pkg::cplx_t w;
		case (k)
			3'd0: begin w.re = 16'sd256;  w.im = 16'sd0;    end
			3'd1: begin w.re = 16'sd237;  w.im = -16'sd98;  end
			3'd2: begin w.re = 16'sd181;  w.im = -16'sd181; end
			3'd3: begin w.re = 16'sd98;   w.im = -16'sd237; end
			3'd4: begin w.re = 16'sd0;    w.im = -16'sd256; end
			3'd5: begin w.re = -16'sd98;  w.im = -16'sd237; end
			3'd6: begin w.re = -16'sd181; w.im = -16'sd181; end
			default: begin
				w.re = -16'sd237;
				w.im = -16'sd98;
			end
		endcase
		return w;
	endfunction

	// every lane reads the same table
	always_comb begin
		for (int b = 0; b < fft16_pkg::N_BFLY; b++) begin
			o_tw[b] = tw_lookup(i_tw_idx[b]);
		end
	end

endmodule

// File: list.f
+incdir+.
fft16_pkg.sv
fft16_twiddle_rom.sv
fft16_butterfly.sv
fft16_stage_router.sv
fft16_sequencer.sv
fft16_top.sv
tb_fft16.sv

// File: run_sim.sh
#!/bin/sh
# build and run the FFT testbench with Verilator

LOG=sim.log
OBJ_DIR=obj_dir
EXE=tb_fft16_sim

verilator --binary --timing -Wno-fatal --top-module tb_fft16 \
	-Mdir "$OBJ_DIR" -o "$EXE" -f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# verdict comes from the log
if grep -q "Simulation finished: PASS" "$LOG"; then
	echo "run_sim: passed"
	exit 0
else
	echo "run_sim: failed, see $LOG"
	exit 1
fi

// File: tb_fft16_model.svh
`ifndef TB_FFT16_MODEL_SVH
`define TB_FFT16_MODEL_SVH

// keep the low 16 bits, sign extended
function automatic int wrap16(input int v);
	fft16_pkg::sample_t s;
	s = v[15:0];
	return int'(s);
endfunction

// fixed point radix-2 DIT FFT, natural order in and out
function automatic fft16_pkg::frame_t fft_model(input fft16_pkg::frame_t x);
	int tw_re [8] = '{256, 237, 181, 98, 0, -98, -181, -237};
	int tw_im [8] = '{0, -98, -181, -237, -256, -237, -181, -98};
	int a_re [16];
	int a_im [16];
	int r;
	int h;
	int t;
	int u;
	int w;
	int p_re;
	int p_im;
	int top_re;
	int top_im;
	fft16_pkg::frame_t y;

	// bit reversed load
	for (int i = 0; i < 16; i++) begin
		r = ((i & 1) << 3) | ((i & 2) << 1) | ((i & 4) >> 1) | ((i & 8) >> 3);
		a_re[i] = x[r].re;
		a_im[i] = x[r].im;
	end

	for (int s = 0; s < 4; s++) begin
		h = 1 << s;
		for (int g = 0; g < 16; g += 2 * h) begin
			for (int j = 0; j < h; j++) begin
				t = g + j;
				u = t + h;
				w = j * 8 / h;
				p_re = (a_re[u] * tw_re[w] - a_im[u] * tw_im[w]) >>> fft16_pkg::FRACTION;
				p_im = (a_re[u] * tw_im[w] + a_im[u] * tw_re[w]) >>> fft16_pkg::FRACTION;
				p_re = wrap16(p_re);
				p_im = wrap16(p_im);
				top_re = a_re[t];
				top_im = a_im[t];
				a_re[t] = wrap16(top_re + p_re);
				a_im[t] = wrap16(top_im + p_im);
				a_re[u] = wrap16(top_re - p_re);
				a_im[u] = wrap16(top_im - p_im);
			end
		end
	end

	for (int i = 0; i < 16; i++) begin
		y[i].re = fft16_pkg::sample_t'(a_re[i]);
		y[i].im = fft16_pkg::sample_t'(a_im[i]);
	end
	return y;
endfunction

`endif

// File: tb_fft16.sv
module tb_fft16;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_FRAMES   = 15;
	localparam int DONE_EDGES = 4;
	localparam int DONE_LIMIT = 20;

	logic              clk;
	logic              rst_n;
	logic              start;
	fft16_pkg::frame_t frame_in;
	fft16_pkg::frame_t frame_out;
	logic              busy;
	logic              done;

	int     errors;
	integer seed;

	`include "tb_fft16_model.svh"

	fft16_top dut (
		.i_clk   (clk),
		.i_rst_n (rst_n),
		.i_start (start),
		.i_frame (frame_in),
		.o_frame (frame_out),
		.o_busy  (busy),
		.o_done  (done)
	);

	always #4 clk = ~clk;

	// watchdog
	initial begin
		#((N_FRAMES * 10 + 50) * 8);
		errors++;
		$display("ERROR: timeout, the tests did not finish in time");
		$display("errors: %0d", errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////
	// helpers and compare tasks
	//////////////////////////////////////////////////
	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_sample(input string name, input fft16_pkg::sample_t exp,
			input fft16_pkg::sample_t act);
		if (act !== exp) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_frame(input fft16_pkg::frame_t exp, input fft16_pkg::frame_t act);
		for (int i = 0; i < fft16_pkg::N_POINTS; i++) begin
			check_sample($sformatf("o_frame[%0d].re", i), exp[i].re, act[i].re);
			check_sample($sformatf("o_frame[%0d].im", i), exp[i].im, act[i].im);
		end
	endtask

	task automatic make_random_frame(output fft16_pkg::frame_t f);
		for (int i = 0; i < fft16_pkg::N_POINTS; i++) begin
			f[i].re = fft16_pkg::sample_t'($random(seed) % 65);
			f[i].im = fft16_pkg::sample_t'($random(seed) % 65);
		end
	endtask

	// returns one ns after the start edge
	task automatic start_frame(input fft16_pkg::frame_t f);
		frame_in = f;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		check_bit("o_busy", 1'b1, busy);
		check_bit("o_done", 1'b0, done);
		check_frame(f, frame_out);
	endtask

	task automatic wait_done(input int edges_before, output int edges);
		edges = edges_before;
		while (done !== 1'b1 && edges < DONE_LIMIT) begin
			next_cycle();
			edges++;
		end
	endtask

	task automatic check_done_edges(input int edges);
		if (done !== 1'b1) begin
			errors++;
			$display("ERROR: no done pulse within %0d cycles of the start", DONE_LIMIT);
		end else if (edges != DONE_EDGES) begin
			errors++;
			$display("ERROR: done pulse came %0d edges after the start edge, not %0d",
				edges, DONE_EDGES);
		end else begin
			check_bit("o_busy", 1'b0, busy);
		end
	endtask

	task automatic finish_frame(input fft16_pkg::frame_t exp);
		int edges;
		wait_done(0, edges);
		check_done_edges(edges);
		check_frame(exp, frame_out);
	endtask

	// done lasts a single cycle
	task automatic check_done_drops;
		next_cycle();
		check_bit("o_done", 1'b0, done);
		check_bit("o_busy", 1'b0, busy);
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic test_reset;
		check_bit("o_busy", 1'b0, busy);
		check_bit("o_done", 1'b0, done);
		check_frame('0, frame_out);
	endtask

	task automatic test_impulse;
		fft16_pkg::frame_t f;
		fft16_pkg::frame_t exp;
		f = '0;
		f[0].re = 16'sd64;
		exp = '0;
		for (int i = 0; i < fft16_pkg::N_POINTS; i++) begin
			exp[i].re = 16'sd64;
		end
		start_frame(f);
		finish_frame(exp);
		check_done_drops();
	endtask

	task automatic test_constant;
		fft16_pkg::frame_t f;
		fft16_pkg::frame_t exp;
		f = '0;
		for (int i = 0; i < fft16_pkg::N_POINTS; i++) begin
			f[i].re = 16'sd4;
		end
		// all energy lands in bin 0
		exp = '0;
		exp[0].re = 16'sd64;
		start_frame(f);
		finish_frame(exp);
		check_done_drops();
	endtask

	task automatic test_random;
		fft16_pkg::frame_t f;
		for (int n = 0; n < 10; n++) begin
			make_random_frame(f);
			start_frame(f);
			finish_frame(fft_model(f));
			check_done_drops();
		end
	endtask

	task automatic test_ignored_start;
		fft16_pkg::frame_t f1;
		fft16_pkg::frame_t f2;
		int edges;
		make_random_frame(f1);
		make_random_frame(f2);
		start_frame(f1);
		// second start lands on E2 while busy
		next_cycle();
		frame_in = f2;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		wait_done(2, edges);
		check_done_edges(edges);
		check_frame(fft_model(f1), frame_out);
		for (int i = 0; i < 6; i++) begin
			next_cycle();
			if (done === 1'b1) begin
				errors++;
				$display("ERROR: a second done pulse followed the ignored start");
			end
		end
	endtask

	task automatic test_back_to_back;
		fft16_pkg::frame_t fa;
		fft16_pkg::frame_t fb;
		make_random_frame(fa);
		make_random_frame(fb);
		start_frame(fa);
		finish_frame(fft_model(fa));
		check_done_drops();
		// result still held in the cycle after done
		check_frame(fft_model(fa), frame_out);
		// next start is sampled on the edge that ends this cycle
		start_frame(fb);
		finish_frame(fft_model(fb));
		check_done_drops();
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		frame_in = '0;
		errors = 0;
		seed = 87;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_reset();
		test_impulse();
		test_constant();
		test_random();
		test_ignored_start();
		test_back_to_back();

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
